//--- src/gb_bus_pkg.sv
// bus types, register addresses, interrupt indices and vector constants
`default_nettype none

package gb_bus_pkg;

	typedef logic [15:0] cpu_addr_t;  // cpu address
	typedef logic [7:0]  cpu_data_t;  // cpu data byte
	typedef logic [2:0]  wram_bank_t; // svbk bank number
	typedef logic [4:0]  irq_vec_t;   // one bit per interrupt source

	// interrupt sources, bit 0 wins
	localparam int NUM_IRQ    = 5;
	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCDC   = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	localparam cpu_data_t IRQ_VEC_BASE = 8'h40; // rst vector of vblank
	localparam cpu_data_t IRQ_VEC_STEP = 8'h08;

	// io registers
	localparam cpu_addr_t ADDR_P1   = 16'hFF00;
	localparam cpu_addr_t ADDR_IF   = 16'hFF0F;
	localparam cpu_addr_t ADDR_KEY1 = 16'hFF4D;
	localparam cpu_addr_t ADDR_SVBK = 16'hFF70;
	localparam cpu_addr_t ADDR_FF72 = 16'hFF72;
	localparam cpu_addr_t ADDR_FF73 = 16'hFF73;
	localparam cpu_addr_t ADDR_FF74 = 16'hFF74;
	localparam cpu_addr_t ADDR_FF75 = 16'hFF75;
	localparam cpu_addr_t ADDR_IE   = 16'hFFFF;

	localparam int WRAM_BANK_BITS = 12; // 4k per bank
	localparam int WRAM_ADDR_W    = 15; // 8 banks of 4k
	localparam int ZPRAM_ADDR_W   = 7;  // ff80-fffe
	localparam cpu_data_t OPEN_BUS = 8'hFF;

endpackage

`default_nettype wire

//--- src/sync_ram.sv
// single-port byte ram with registered read
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
	parameter int ADDR_W = 7
) (
	input  logic              clk_sys,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [7:0]        wdata_i,
	output logic [7:0]        rdata_o
);

	logic [7:0] mem [2**ADDR_W];

	// read is registered every clock
	always_ff @(posedge clk_sys) begin
		if (we_i)
			mem[addr_i] <= wdata_i;
		rdata_o <= mem[addr_i];  // old data on a write cycle
	end

endmodule

`default_nettype wire

//--- src/bus_decode.sv
// cpu address decode, write edge detect, per-target write strobes, wram address build
`timescale 1ns/1ps
`default_nettype none

module bus_decode import gb_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  logic       ce_cpu_i,
	input  logic       is_gbc_i,
	input  logic       is_gbc_game_i,
	input  cpu_addr_t  cpu_addr_i,
	input  logic       cpu_wr_n_i,
	input  wram_bank_t wram_bank_i,
	output logic       wr_ie_o,
	output logic       wr_if_o,
	output logic       wr_p1_o,
	output logic       wr_key1_o,
	output logic       wr_svbk_o,
	output logic       wr_spare_o,
	output logic       wr_wram_o,
	output logic       wr_zpram_o,
	output logic       sel_if_o,
	output logic       sel_ie_o,
	output logic       sel_p1_o,
	output logic       sel_key1_o,
	output logic       sel_svbk_o,
	output logic [3:0] sel_spare_o,  // ff72, ff73, ff74, ff75
	output logic       sel_wram_o,
	output logic       sel_zpram_o,
	output logic [WRAM_ADDR_W-1:0] wram_addr_o
);

	logic old_wr_n;  // wr_n seen on the last cpu cycle
	logic wr_edge;
	logic cgb_mode;  // cgb hw running a cgb cartridge

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			old_wr_n <= 1'b1;
		end else if (ce_cpu_i) begin
			old_wr_n <= cpu_wr_n_i;
		end
	end

	assign wr_edge  = ce_cpu_i & old_wr_n & ~cpu_wr_n_i; // first cpu cycle of a write
	assign cgb_mode = is_gbc_i & is_gbc_game_i;

	// ------------------------------------------------------------------
	// region match
	assign sel_if_o       = (cpu_addr_i == ADDR_IF);
	assign sel_ie_o       = (cpu_addr_i == ADDR_IE);
	assign sel_p1_o       = (cpu_addr_i == ADDR_P1);
	assign sel_key1_o     = cgb_mode & (cpu_addr_i == ADDR_KEY1);
	assign sel_svbk_o     = cgb_mode & (cpu_addr_i == ADDR_SVBK);
	assign sel_spare_o[0] = is_gbc_i & (cpu_addr_i == ADDR_FF72);
	assign sel_spare_o[1] = is_gbc_i & (cpu_addr_i == ADDR_FF73);
	assign sel_spare_o[2] = cgb_mode & (cpu_addr_i == ADDR_FF74);  // cgb game only
	assign sel_spare_o[3] = is_gbc_i & (cpu_addr_i == ADDR_FF75);
	// c000-fdff, fe00 and up is oam/io
	assign sel_wram_o  = (cpu_addr_i[15:14] == 2'b11) & ~&cpu_addr_i[13:9];
	assign sel_zpram_o = (cpu_addr_i[15:7] == 9'h1FF) & (cpu_addr_i != ADDR_IE);

	// ------------------------------------------------------------------
	// one strobe per write
	assign wr_ie_o    = wr_edge & sel_ie_o;
	assign wr_if_o    = wr_edge & sel_if_o;
	assign wr_p1_o    = wr_edge & sel_p1_o;
	assign wr_key1_o  = wr_edge & sel_key1_o;
	assign wr_svbk_o  = wr_edge & sel_svbk_o;
	assign wr_spare_o = wr_edge & (|sel_spare_o);
	assign wr_wram_o  = wr_edge & sel_wram_o;
	assign wr_zpram_o = wr_edge & sel_zpram_o;

	// bank 0 fixed at c000, switchable bank from d000
	assign wram_addr_o = cpu_addr_i[WRAM_BANK_BITS] ?
		{wram_bank_i, cpu_addr_i[WRAM_BANK_BITS-1:0]} :
		{wram_bank_t'(0), cpu_addr_i[WRAM_BANK_BITS-1:0]};

	a_one_strobe: assert property (@(posedge clk_sys) disable iff (reset_ss)
		$onehot0({wr_ie_o, wr_if_o, wr_p1_o, wr_key1_o, wr_svbk_o, wr_spare_o,
			wr_wram_o, wr_zpram_o}))
		else $error("bus_decode: several write strobes in one cycle");

endmodule

`default_nettype wire

//--- src/irq_ctrl.sv
// IE/IF registers, source edge capture, priority vector and acknowledge clearing
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl import gb_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  logic       ce_cpu_i,
	input  logic [3:0] irq_src_i,   // vblank .. serial levels
	input  logic       joy_irq_i,
	input  logic       wr_ie_i,
	input  logic       wr_if_i,
	input  cpu_data_t  cpu_do_i,
	input  logic       cpu_iorq_n_i,
	input  logic       cpu_m1_n_i,
	output cpu_data_t  ie_o,
	output irq_vec_t   if_o,
	output cpu_data_t  irq_vec_o,
	output logic       irq_ack_o,
	output logic       irq_n_o
);

	cpu_data_t  ie_q;     // all eight bits r/w
	irq_vec_t   if_q;
	irq_vec_t   if_nxt;
	irq_vec_t   pending;  // flagged and enabled
	irq_vec_t   set_mask;
	irq_vec_t   clr_mask; // highest priority pending bit
	logic [3:0] src_q;    // source levels on last cpu cycle
	logic       ack_q;

	assign pending   = if_q & ie_q[NUM_IRQ-1:0];
	assign irq_ack_o = ~cpu_iorq_n_i & ~cpu_m1_n_i;  // int ack cycle
	assign irq_n_o   = ~|pending;

	// rising source edges, joypad arrives as a pulse already
	assign set_mask[IRQ_SERIAL:IRQ_VBLANK] = irq_src_i & ~src_q;
	assign set_mask[IRQ_JOYPAD]            = joy_irq_i;

	// lowest index wins
	always_comb begin
		irq_vec_o = 8'h00;
		clr_mask  = '0;
		for (int i = NUM_IRQ - 1; i >= 0; i--) begin
			if (pending[i]) begin
				irq_vec_o = IRQ_VEC_BASE + cpu_data_t'(i) * IRQ_VEC_STEP;
				clr_mask  = irq_vec_t'(1) << i;
			end
		end
	end

	always_comb begin
		if_nxt = if_q;
		if (ce_cpu_i) begin
			if_nxt = if_nxt | set_mask;
			if (ack_q & ~irq_ack_o)      // ack just ended
				if_nxt = if_nxt & ~clr_mask;
		end
		if (wr_if_i)
			if_nxt = cpu_do_i[NUM_IRQ-1:0];  // cpu write wins
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_q  <= '0;
			if_q  <= '0;
			src_q <= '0;
			ack_q <= 1'b0;
		end else begin
			if_q <= if_nxt;
			if (ce_cpu_i) begin
				src_q <= irq_src_i;
				ack_q <= irq_ack_o;
			end
			if (wr_ie_i)
				ie_q <= cpu_do_i;
		end
	end

	assign ie_o = ie_q;
	assign if_o = if_q;

	// acknowledged flag is gone once the ack has ended
	a_ack_clear: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(ce_cpu_i && ack_q && !irq_ack_o && !wr_if_i) |=> ((if_q & $past(clr_mask)) == '0))
		else $error("irq_ctrl: acknowledged flag still set after the ack");

endmodule

`default_nettype wire

//--- src/cgb_regs.sv
// KEY1 speed switch and cpu clock enable, SVBK bank, FF72-FF75 registers
`timescale 1ns/1ps
`default_nettype none

module cgb_regs import gb_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  logic       ce_i,
	input  logic       ce_2x_i,
	input  logic       is_gbc_i,
	input  logic       cpu_stop_i,
	input  logic       wr_key1_i,
	input  logic       wr_svbk_i,
	input  logic       wr_spare_i,
	input  cpu_addr_t  cpu_addr_i,
	input  cpu_data_t  cpu_do_i,
	output logic       ce_cpu_o,
	output logic       speed_o,
	output logic       prepare_o,
	output wram_bank_t wram_bank_o,
	output cpu_data_t  ff72_o,
	output cpu_data_t  ff73_o,
	output cpu_data_t  ff74_o,
	output logic [2:0] ff75_o   // only bits 6:4 exist
);

	logic       speed_q;   // 1 = double speed
	logic       prepare_q; // armed by key1 bit 0
	wram_bank_t bank_q;

	// ------------------------------------------------------------------
	// speed switch
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			speed_q   <= 1'b0;
			prepare_q <= 1'b0;
		end else begin
			if (wr_key1_i)
				prepare_q <= cpu_do_i[0];
			// stop with prepare set flips the speed
			if (ce_2x_i && is_gbc_i && prepare_q && cpu_stop_i) begin
				speed_q   <= ~speed_q;
				prepare_q <= 1'b0;
			end
		end
	end

	assign ce_cpu_o  = speed_q ? ce_2x_i : ce_i;
	assign speed_o   = speed_q;
	assign prepare_o = prepare_q;

	// ------------------------------------------------------------------
	// svbk and the unused cgb registers
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			bank_q <= 3'd1;
			ff72_o <= '0;
			ff73_o <= '0;
			ff74_o <= '0;
			ff75_o <= '0;
		end else begin
			if (wr_svbk_i)
				bank_q <= (cpu_do_i[2:0] == 3'd0) ? 3'd1 : cpu_do_i[2:0]; // 0 maps to 1
			if (wr_spare_i) begin
				if (cpu_addr_i == ADDR_FF72) ff72_o <= cpu_do_i;
				if (cpu_addr_i == ADDR_FF73) ff73_o <= cpu_do_i;
				if (cpu_addr_i == ADDR_FF74) ff74_o <= cpu_do_i;
				if (cpu_addr_i == ADDR_FF75) ff75_o <= cpu_do_i[6:4];
			end
		end
	end

	assign wram_bank_o = bank_q;

	// a stop with prepare armed switches speed and disarms prepare
	a_speed_flip: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(ce_2x_i && is_gbc_i && prepare_q && cpu_stop_i) |=>
			((speed_q != $past(speed_q)) && !prepare_q))
		else $error("cgb_regs: stop with prepare set did not switch speed");

endmodule

`default_nettype wire

//--- src/joypad.sv
// P1 select bits, joypad register value and falling-edge interrupt request
`timescale 1ns/1ps
`default_nettype none

module joypad import gb_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  logic       ce_cpu_i,
	input  logic       wr_p1_i,
	input  cpu_data_t  cpu_do_i,
	input  logic [3:0] joy_din_i,  // p10..p13, low = pressed
	output logic [1:0] joy_p54_o,
	output cpu_data_t  p1_o,
	output logic       joy_irq_o
);

	logic [1:0] p54_q;
	logic [3:0] din_s1, din_s2; // synchronizer
	logic [3:0] din_old;        // previous synced value

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			p54_q   <= 2'b00;
			din_s1  <= 4'hF;  // released
			din_s2  <= 4'hF;
			din_old <= 4'hF;
		end else begin
			if (wr_p1_i)
				p54_q <= cpu_do_i[5:4];
			if (ce_cpu_i) begin
				din_s1  <= joy_din_i;
				din_s2  <= din_s1;
				din_old <= din_s2;
			end
		end
	end

	assign joy_p54_o = p54_q;
	assign p1_o      = {2'b11, p54_q, joy_din_i};
	assign joy_irq_o = |(~din_s2 & din_old);  // any line going low

endmodule

`default_nettype wire

//--- src/bus_read_mux.sv
// priority read-data multiplexer toward the cpu
`timescale 1ns/1ps
`default_nettype none

module bus_read_mux import gb_bus_pkg::*; (
	input  logic       sel_if_i,
	input  logic       sel_ie_i,
	input  logic       sel_p1_i,
	input  logic       sel_key1_i,
	input  logic       sel_svbk_i,
	input  logic [3:0] sel_spare_i,  // ff72..ff75
	input  logic       sel_wram_i,
	input  logic       sel_zpram_i,
	input  logic       irq_ack_i,
	input  cpu_data_t  irq_vec_i,
	input  cpu_data_t  ie_i,
	input  irq_vec_t   if_i,
	input  logic       speed_i,
	input  logic       prepare_i,
	input  wram_bank_t wram_bank_i,
	input  cpu_data_t  p1_i,
	input  cpu_data_t  ff72_i,
	input  cpu_data_t  ff73_i,
	input  cpu_data_t  ff74_i,
	input  logic [2:0] ff75_i,
	input  cpu_data_t  wram_q_i,
	input  cpu_data_t  zpram_q_i,
	output cpu_data_t  cpu_di_o
);

	// first match wins
	always_comb begin
		if (irq_ack_i)           cpu_di_o = irq_vec_i;           // ack cycle
		else if (sel_if_i)       cpu_di_o = {3'b111, if_i};
		else if (sel_key1_i)     cpu_di_o = {speed_i, 6'h3F, prepare_i};
		else if (sel_svbk_i)     cpu_di_o = {5'h1F, wram_bank_i};
		else if (sel_p1_i)       cpu_di_o = p1_i;
		else if (sel_wram_i)     cpu_di_o = wram_q_i;
		else if (sel_zpram_i)    cpu_di_o = zpram_q_i;
		else if (sel_ie_i)       cpu_di_o = ie_i;
		else if (sel_spare_i[0]) cpu_di_o = ff72_i;
		else if (sel_spare_i[1]) cpu_di_o = ff73_i;
		else if (sel_spare_i[2]) cpu_di_o = ff74_i;
		else if (sel_spare_i[3]) cpu_di_o = {1'b1, ff75_i, 4'hF}; // bits 6:4 only
		else                     cpu_di_o = OPEN_BUS;
	end

endmodule

`default_nettype wire

//--- src/gb_sys_top.sv
// bus glue top level with decoder, interrupt controller, cgb registers, joypad and rams
`timescale 1ns/1ps
`default_nettype none

module gb_sys_top import gb_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  logic       ce_i,
	input  logic       ce_2x_i,
	input  logic       is_gbc_i,
	input  logic       is_gbc_game_i,
	input  cpu_addr_t  cpu_addr_i,
	input  cpu_data_t  cpu_do_i,
	input  logic       cpu_wr_n_i,
	input  logic       cpu_iorq_n_i,
	input  logic       cpu_m1_n_i,
	input  logic       cpu_stop_i,
	input  logic [3:0] irq_src_i,  // vblank, lcdc, timer, serial
	input  logic [3:0] joy_din_i,  // buttons, active low
	output cpu_data_t  cpu_di_o,
	output logic       irq_n_o,
	output logic       ce_cpu_o,   // also the internal cpu enable
	output logic       speed_o,
	output logic [1:0] joy_p54_o
);

	// write strobes
	logic wr_ie, wr_if, wr_p1, wr_key1, wr_svbk, wr_spare, wr_wram, wr_zpram;
	// read selects
	logic sel_if, sel_ie, sel_p1, sel_key1, sel_svbk, sel_wram, sel_zpram;
	logic [3:0] sel_spare;

	logic [WRAM_ADDR_W-1:0] wram_addr;
	wram_bank_t wram_bank;
	cpu_data_t  ie, irq_vec, p1, ff72, ff73, ff74, wram_q, zpram_q;
	irq_vec_t   iflag;
	logic [2:0] ff75;
	logic       irq_ack, prepare, joy_irq;

	bus_decode bus_decode_i (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce_cpu_i(ce_cpu_o),
		.is_gbc_i(is_gbc_i), .is_gbc_game_i(is_gbc_game_i),
		.cpu_addr_i(cpu_addr_i), .cpu_wr_n_i(cpu_wr_n_i), .wram_bank_i(wram_bank),
		.wr_ie_o(wr_ie), .wr_if_o(wr_if), .wr_p1_o(wr_p1), .wr_key1_o(wr_key1),
		.wr_svbk_o(wr_svbk), .wr_spare_o(wr_spare), .wr_wram_o(wr_wram),
		.wr_zpram_o(wr_zpram),
		.sel_if_o(sel_if), .sel_ie_o(sel_ie), .sel_p1_o(sel_p1), .sel_key1_o(sel_key1),
		.sel_svbk_o(sel_svbk), .sel_spare_o(sel_spare), .sel_wram_o(sel_wram),
		.sel_zpram_o(sel_zpram), .wram_addr_o(wram_addr)
	);

	irq_ctrl irq_ctrl_i (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce_cpu_i(ce_cpu_o),
		.irq_src_i(irq_src_i), .joy_irq_i(joy_irq), .wr_ie_i(wr_ie), .wr_if_i(wr_if),
		.cpu_do_i(cpu_do_i), .cpu_iorq_n_i(cpu_iorq_n_i), .cpu_m1_n_i(cpu_m1_n_i),
		.ie_o(ie), .if_o(iflag), .irq_vec_o(irq_vec), .irq_ack_o(irq_ack),
		.irq_n_o(irq_n_o)
	);

	cgb_regs cgb_regs_i (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce_i(ce_i), .ce_2x_i(ce_2x_i),
		.is_gbc_i(is_gbc_i), .cpu_stop_i(cpu_stop_i), .wr_key1_i(wr_key1),
		.wr_svbk_i(wr_svbk), .wr_spare_i(wr_spare), .cpu_addr_i(cpu_addr_i),
		.cpu_do_i(cpu_do_i),
		.ce_cpu_o(ce_cpu_o), .speed_o(speed_o), .prepare_o(prepare),
		.wram_bank_o(wram_bank), .ff72_o(ff72), .ff73_o(ff73), .ff74_o(ff74),
		.ff75_o(ff75)
	);

	joypad joypad_i (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce_cpu_i(ce_cpu_o), .wr_p1_i(wr_p1),
		.cpu_do_i(cpu_do_i), .joy_din_i(joy_din_i),
		.joy_p54_o(joy_p54_o), .p1_o(p1), .joy_irq_o(joy_irq)
	);

	// c000-dfff, mirrored up to fdff
	sync_ram #(.ADDR_W(WRAM_ADDR_W)) wram_i (
		.clk_sys(clk_sys), .we_i(wr_wram), .addr_i(wram_addr), .wdata_i(cpu_do_i),
		.rdata_o(wram_q)
	);

	// ff80-fffe
	sync_ram #(.ADDR_W(ZPRAM_ADDR_W)) zpram_i (
		.clk_sys(clk_sys), .we_i(wr_zpram), .addr_i(cpu_addr_i[ZPRAM_ADDR_W-1:0]),
		.wdata_i(cpu_do_i), .rdata_o(zpram_q)
	);

	bus_read_mux bus_read_mux_i (
		.sel_if_i(sel_if), .sel_ie_i(sel_ie), .sel_p1_i(sel_p1), .sel_key1_i(sel_key1),
		.sel_svbk_i(sel_svbk), .sel_spare_i(sel_spare), .sel_wram_i(sel_wram),
		.sel_zpram_i(sel_zpram), .irq_ack_i(irq_ack), .irq_vec_i(irq_vec),
		.ie_i(ie), .if_i(iflag), .speed_i(speed_o), .prepare_i(prepare),
		.wram_bank_i(wram_bank), .p1_i(p1), .ff72_i(ff72), .ff73_i(ff73),
		.ff74_i(ff74), .ff75_i(ff75), .wram_q_i(wram_q), .zpram_q_i(zpram_q),
		.cpu_di_o(cpu_di_o)
	);

endmodule

`default_nettype wire

//--- verif/tb_gb_sys.sv
// testbench for the bus glue with stimulus, small reference model, checking assertions and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_gb_sys import gb_bus_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000;  // all tests take well under 1000 cycles
	localparam logic [1:0] K_DI  = 2'd0;   // compare cpu_di_o
	localparam logic [1:0] K_IRQ = 2'd1;   // compare irq_n_o
	localparam logic [1:0] K_P54 = 2'd2;   // compare joy_p54_o
	localparam logic [1:0] K_SPD = 2'd3;   // compare speed_o

	logic       clk_sys = 1'b0;
	logic       reset_ss;
	logic       ce_i, ce_2x_i, is_gbc_i, is_gbc_game_i;
	cpu_addr_t  cpu_addr_i;
	cpu_data_t  cpu_do_i;
	logic       cpu_wr_n_i, cpu_iorq_n_i, cpu_m1_n_i, cpu_stop_i;
	logic [3:0] irq_src_i;
	logic [3:0] joy_din_i;
	cpu_data_t  cpu_di_o;
	logic       irq_n_o, ce_cpu_o, speed_o;
	logic [1:0] joy_p54_o;

	logic       chk_en;     // sample cycle flag
	logic       ce_win;     // ce_cpu_o must stay high
	logic [1:0] chk_kind;
	cpu_data_t  exp_val;
	cpu_data_t  obs;
	string      test_name;
	int         cycles = 0;
	int         seed;
	cpu_data_t  rnd [7];

	// reference model state
	wram_bank_t bank_m;
	cpu_data_t  wram_m [int];  // key is bank * 4k + offset
	cpu_data_t  zp_m [int];

	always #4 clk_sys = ~clk_sys;              // 8 ns
	always @(posedge clk_sys) ce_i <= ~ce_i;   // every other cycle

	gb_sys_top gb_sys_top_i (.*);

	// ------------------------------------------------------------------
	// checking
	always_comb begin
		case (chk_kind)
			K_IRQ:   obs = {7'd0, irq_n_o};
			K_P54:   obs = {6'd0, joy_p54_o};
			K_SPD:   obs = {7'd0, speed_o};
			default: obs = cpu_di_o;
		endcase
	end

	task automatic stop_run();
		$display("TB FAILED");
		$fatal(1, "run stopped at cycle %0d", cycles);
	endtask

	a_value: assert property (@(posedge clk_sys) disable iff (reset_ss)
		chk_en |-> (obs == exp_val))
		else begin
			$display("Fail %s: expected %h actual %h", test_name, $sampled(exp_val),
				$sampled(obs));
			stop_run();
		end

	a_ce_fast: assert property (@(posedge clk_sys) disable iff (reset_ss)
		ce_win |-> ce_cpu_o)
		else begin
			$display("Fail %s: ce_cpu_o expected 1 actual %b", test_name, $sampled(ce_cpu_o));
			stop_run();
		end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_run();
		end
	end

	// ------------------------------------------------------------------
	// bus tasks
	function automatic int wram_key(input cpu_addr_t addr);
		// bank 0 below d000, svbk bank above, e000 mirror drops bit 13
		return (addr[12] ? int'(bank_m) : 0) * 4096 + int'(addr[11:0]);
	endfunction

	function automatic cpu_data_t ram_model(input cpu_addr_t addr);
		if (addr >= 16'hFF80)
			return zp_m[int'(addr[6:0])];
		return wram_m[wram_key(addr)];
	endfunction

	task automatic check_obs(input logic [1:0] kind, input cpu_data_t exp);
		chk_kind <= kind;
		exp_val  <= exp;
		chk_en   <= 1'b1;  // compared on the next edge
		@(posedge clk_sys);
		chk_en   <= 1'b0;
	endtask

	task automatic write_byte(input cpu_addr_t addr, input cpu_data_t data);
		cpu_addr_i <= addr;
		cpu_do_i   <= data;
		cpu_wr_n_i <= 1'b0;
		repeat (4) @(posedge clk_sys);
		cpu_wr_n_i <= 1'b1;
		repeat (2) @(posedge clk_sys);  // let a cpu cycle see wr_n high
		if (addr == ADDR_SVBK)
			bank_m = (data[2:0] == 3'd0) ? 3'd1 : data[2:0];
		else if (addr >= 16'hC000 && addr < 16'hFE00)
			wram_m[wram_key(addr)] = data;
		else if (addr >= 16'hFF80 && addr != ADDR_IE)
			zp_m[int'(addr[6:0])] = data;
	endtask

	task automatic read_check(input cpu_addr_t addr, input cpu_data_t exp);
		cpu_addr_i <= addr;
		repeat (3) @(posedge clk_sys);
		check_obs(K_DI, exp);
	endtask

	task automatic ack_check(input cpu_data_t vec);
		cpu_iorq_n_i <= 1'b0;
		cpu_m1_n_i   <= 1'b0;
		@(posedge clk_sys);
		check_obs(K_DI, vec);
		@(posedge clk_sys);
		cpu_iorq_n_i <= 1'b1;  // flag clears on the next cpu cycle
		cpu_m1_n_i   <= 1'b1;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic pulse_sources(input logic [3:0] src);
		irq_src_i <= src;
		repeat (2) @(posedge clk_sys);  // spans one ce edge
		irq_src_i <= 4'h0;
		@(posedge clk_sys);
	endtask

	// ------------------------------------------------------------------
	// test sequence
	initial begin
		seed = 45;
		for (int i = 0; i < 7; i++) begin
			rnd[i] = 8'($random(seed));
		end
		reset_ss      = 1'b1;
		ce_i          = 1'b0;
		ce_2x_i       = 1'b1;
		is_gbc_i      = 1'b1;
		is_gbc_game_i = 1'b1;
		cpu_addr_i    = '0;
		cpu_do_i      = '0;
		cpu_wr_n_i    = 1'b1;
		cpu_iorq_n_i  = 1'b1;
		cpu_m1_n_i    = 1'b1;
		cpu_stop_i    = 1'b0;
		irq_src_i     = 4'h0;
		joy_din_i     = 4'hF;  // nothing pressed
		chk_en        = 1'b0;
		ce_win        = 1'b0;
		chk_kind      = K_DI;
		exp_val       = '0;
		bank_m        = 3'd1;
		test_name     = "reset";
		repeat (5) @(posedge clk_sys);
		reset_ss <= 1'b0;
		@(posedge clk_sys);

		test_name = "wram_bank";
		read_check(ADDR_SVBK, 8'hF9);
		write_byte(ADDR_SVBK, 8'h00);  // 0 selects bank 1
		read_check(ADDR_SVBK, 8'hF9);
		write_byte(ADDR_SVBK, 8'h02);
		write_byte(16'hD000, rnd[0]);
		write_byte(ADDR_SVBK, 8'h03);
		write_byte(16'hD000, rnd[1]);
		write_byte(16'hC000, rnd[2]);
		write_byte(ADDR_SVBK, 8'h02);
		read_check(16'hD000, ram_model(16'hD000));
		write_byte(ADDR_SVBK, 8'h03);
		read_check(16'hD000, ram_model(16'hD000));
		read_check(16'hC000, ram_model(16'hC000));
		read_check(16'hE000, ram_model(16'hE000));  // echo of c000

		test_name = "zero_page";
		write_byte(16'hFF80, rnd[3]);
		write_byte(16'hFFFE, rnd[4]);
		read_check(16'hFF80, ram_model(16'hFF80));
		read_check(16'hFFFE, ram_model(16'hFFFE));
		write_byte(ADDR_IE, rnd[5]);
		read_check(ADDR_IE, rnd[5]);
		read_check(16'hFFFE, ram_model(16'hFFFE));

		test_name = "interrupts";
		write_byte(ADDR_IE, 8'h1F);
		pulse_sources(4'b0101);  // timer and vblank
		read_check(ADDR_IF, 8'hE5);
		check_obs(K_IRQ, 8'h00);
		ack_check(8'h40);
		read_check(ADDR_IF, 8'hE4);
		ack_check(8'h50);
		read_check(ADDR_IF, 8'hE0);
		check_obs(K_IRQ, 8'h01);

		test_name = "joypad";
		write_byte(ADDR_P1, 8'h30);
		check_obs(K_P54, 8'h03);
		read_check(ADDR_P1, 8'hF0 | 8'(joy_din_i));
		joy_din_i <= 4'hE;  // press p10
		repeat (10) @(posedge clk_sys);
		read_check(ADDR_IF, 8'hF0);
		read_check(ADDR_P1, 8'hFE);
		joy_din_i <= 4'hF;

		test_name = "speed_switch";
		write_byte(ADDR_KEY1, 8'h01);
		read_check(ADDR_KEY1, 8'h7F);
		cpu_stop_i <= 1'b1;
		@(posedge clk_sys);
		cpu_stop_i <= 1'b0;
		check_obs(K_SPD, 8'h01);
		ce_win <= 1'b1;
		repeat (4) @(posedge clk_sys);
		ce_win <= 1'b0;
		read_check(ADDR_KEY1, 8'hFE);

		test_name = "spare_regs";
		write_byte(ADDR_FF72, rnd[6]);
		read_check(ADDR_FF72, rnd[6]);
		write_byte(ADDR_FF75, 8'hFF);
		read_check(ADDR_FF75, 8'hFF);
		write_byte(ADDR_FF75, 8'h00);
		read_check(ADDR_FF75, 8'h8F);  // unused bits read 1
		read_check(16'hFF03, OPEN_BUS);

		repeat (2) @(posedge clk_sys);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
src/gb_bus_pkg.sv
src/sync_ram.sv
src/bus_decode.sv
src/irq_ctrl.sv
src/cgb_regs.sv
src/joypad.sv
src/bus_read_mux.sv
src/gb_sys_top.sv
verif/tb_gb_sys.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bus glue testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module tb_gb_sys -o tb_gb_sys
./obj_dir/tb_gb_sys | tee sim.log

if grep -q "TB PASSED" sim.log; then
	exit 0
else
	echo "simulation did not pass, see sim.log"
	exit 1
fi
